/* dv/rvfi_checker.sv */
////////////////////////////////////////////////////////////////////////////
// RVFI tracer checker
// Predicts each retirement record from the DUT inputs and compares it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rvfi_checker (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  rvfi_pkg::id_trace_t  id_trace_i,
  input  rvfi_pkg::ctrl_evt_t  ctrl_evt_i,
  input  rvfi_pkg::lsu_trace_t lsu_trace_i,
  input  rvfi_pkg::rvfi_t      rvfi_i,
  output int                   field_errs_o,
  output int                   proto_errs_o,
  output int                   records_o
);

  import rvfi_pkg::*;

  rvfi_t              exp_rec;
  rvfi_t              rst_rec;
  // Operand and memory fields held for the open instruction
  rvfi_t              held;
  logic               exp_due;
  logic               started;
  logic               open_q;
  logic               trap_pend;
  logic               mem_taken;
  logic [ORDER_W-1:0] n_ret;

  initial begin
    rst_rec      = '0;
    rst_rec.mode = PRIV_LVL_M;
  end

  // Byte enables per access size
  function automatic logic [MASK_W-1:0] size_mask(input mem_type_e size);
    case (size)
      MEM_WORD: return 4'b1111;
      MEM_HALF: return 4'b0011;
      MEM_BYTE: return 4'b0001;
      default:  return 4'b0000;
    endcase
  endfunction

  task automatic check_field(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("** Error %s: expected %h, got %h", name, exp_val, act_val);
      field_errs_o++;
    end
  endtask

  task automatic compare_record();
    check_field("rvfi_o.order", exp_rec.order, rvfi_i.order);
    check_field("rvfi_o.insn", exp_rec.insn, rvfi_i.insn);
    check_field("rvfi_o.trap", exp_rec.trap, rvfi_i.trap);
    check_field("rvfi_o.halt", exp_rec.halt, rvfi_i.halt);
    check_field("rvfi_o.intr", exp_rec.intr, rvfi_i.intr);
    check_field("rvfi_o.mode", exp_rec.mode, rvfi_i.mode);
    check_field("rvfi_o.rs1_addr", exp_rec.rs1_addr, rvfi_i.rs1_addr);
    check_field("rvfi_o.rs2_addr", exp_rec.rs2_addr, rvfi_i.rs2_addr);
    check_field("rvfi_o.rs1_rdata", exp_rec.rs1_rdata, rvfi_i.rs1_rdata);
    check_field("rvfi_o.rs2_rdata", exp_rec.rs2_rdata, rvfi_i.rs2_rdata);
    check_field("rvfi_o.rd_addr", exp_rec.rd_addr, rvfi_i.rd_addr);
    check_field("rvfi_o.rd_wdata", exp_rec.rd_wdata, rvfi_i.rd_wdata);
    check_field("rvfi_o.pc_rdata", exp_rec.pc_rdata, rvfi_i.pc_rdata);
    check_field("rvfi_o.pc_wdata", exp_rec.pc_wdata, rvfi_i.pc_wdata);
    check_field("rvfi_o.mem_addr", exp_rec.mem_addr, rvfi_i.mem_addr);
    check_field("rvfi_o.mem_rmask", exp_rec.mem_rmask, rvfi_i.mem_rmask);
    check_field("rvfi_o.mem_wmask", exp_rec.mem_wmask, rvfi_i.mem_wmask);
    check_field("rvfi_o.mem_rdata", exp_rec.mem_rdata, rvfi_i.mem_rdata);
    check_field("rvfi_o.mem_wdata", exp_rec.mem_wdata, rvfi_i.mem_wdata);
  endtask

  // One sampled input cycle of the reference model
  task automatic step_model();
    logic open_now;
    logic trap_entry;
    open_now   = ctrl_evt_i.instr_new | open_q;
    trap_entry = ctrl_evt_i.pc_set && (ctrl_evt_i.pc_mux == PC_EXC) &&
                 ((ctrl_evt_i.exc_pc_mux == EXC_PC_EXC) ||
                  (ctrl_evt_i.exc_pc_mux == EXC_PC_IRQ));
    if (ctrl_evt_i.instr_new) begin
      started        = 1'b1;
      mem_taken      = 1'b0;
      held.rs1_rdata = id_trace_i.rs1_data;
      held.rs2_rdata = id_trace_i.rs2_data;
    end
    // Only the first response of the open instruction counts
    if (lsu_trace_i.valid && open_now && !mem_taken) begin
      mem_taken      = 1'b1;
      held.mem_addr  = lsu_trace_i.addr;
      held.mem_rdata = lsu_trace_i.rdata;
      held.mem_wdata = lsu_trace_i.wdata;
    end
    exp_due = ctrl_evt_i.instr_ret;
    if (ctrl_evt_i.instr_ret) begin
      exp_rec          = held;
      exp_rec.valid    = 1'b1;
      exp_rec.order    = n_ret;
      exp_rec.insn     = id_trace_i.is_compressed ? {16'h0, id_trace_i.instr_rdata_c} :
                                                    id_trace_i.instr_rdata;
      exp_rec.trap     = id_trace_i.illegal;
      exp_rec.intr     = trap_pend;
      exp_rec.mode     = id_trace_i.priv;
      exp_rec.rs1_addr = id_trace_i.rs1_addr;
      exp_rec.rs2_addr = id_trace_i.rs2_addr;
      exp_rec.rd_addr  = id_trace_i.rd_we ? id_trace_i.rd_addr : '0;
      exp_rec.rd_wdata = (id_trace_i.rd_we && (id_trace_i.rd_addr != '0)) ?
                         id_trace_i.rd_wdata : '0;
      exp_rec.pc_rdata = id_trace_i.pc_id;
      exp_rec.pc_wdata = id_trace_i.pc_if;
      exp_rec.mem_rmask = size_mask(lsu_trace_i.data_type);
      exp_rec.mem_wmask = lsu_trace_i.we ? exp_rec.mem_rmask : '0;
      n_ret = n_ret + 1'b1;
    end
    if (trap_entry) begin
      trap_pend = 1'b1;
    end else if (ctrl_evt_i.instr_ret) begin
      trap_pend = 1'b0;
    end
    open_q = open_now & ~ctrl_evt_i.instr_ret;
  endtask

  // Inputs and outputs are both settled at the falling edge
  always @(negedge clk) begin
    if (rst_ni !== 1'b1) begin
      if (rvfi_i !== rst_rec) begin
        $display("** Error rvfi_o in reset: expected %h, got %h", rst_rec, rvfi_i);
        field_errs_o++;
      end
      held      = '0;
      exp_due   = 1'b0;
      started   = 1'b0;
      open_q    = 1'b0;
      trap_pend = 1'b0;
      mem_taken = 1'b0;
      n_ret     = '0;
    end else begin
      if (exp_due) begin
        records_o++;
        if (rvfi_i.valid !== 1'b1) begin
          $display("Retirement %0d gave no valid record on the next cycle", exp_rec.order);
          proto_errs_o++;
        end else begin
          compare_record();
        end
      end else if (rvfi_i.valid !== 1'b0) begin
        $display("A valid record appeared without a retirement on the cycle before");
        proto_errs_o++;
      end
      if (!started) begin
        check_field("rvfi_o.intr before first retirement", 64'h0, rvfi_i.intr);
        check_field("rvfi_o.mode before first retirement", PRIV_LVL_M, rvfi_i.mode);
        check_field("rvfi_o.order before first retirement", 64'h0, rvfi_i.order);
      end
      step_model();
    end
  end

endmodule

/* dv/tb_rvfi_tracer.sv */
////////////////////////////////////////////////////////////////////////////
// RVFI tracer testbench
// Applies a table of instructions to the tracer and reports the result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rvfi_tracer;

  import rvfi_pkg::*;

  // One instruction of the stimulus table
  typedef struct packed {
    logic [31:0] insn;
    logic        is_c;
    logic [4:0]  rd;
    logic        rd_we;
    logic [31:0] rd_wdata;
    logic        mem;
    logic        store;
    mem_type_e   dtype;
    logic [31:0] addr;
    logic        pc_set;
    exc_pc_sel_e exc;
    logic        illegal;
    priv_lvl_e   priv;
  } row_t;

  logic       clk    = 1'b0;
  logic       rst_ni = 1'b0;
  id_trace_t  id_trace;
  ctrl_evt_t  ctrl_evt;
  lsu_trace_t lsu_trace;
  rvfi_t      rvfi;
  row_t       rows [8];
  integer     seed;
  int         field_errs;
  int         proto_errs;
  int         records;

  rvfi_tracer u_rvfi_tracer (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .id_trace_i  (id_trace),
    .ctrl_evt_i  (ctrl_evt),
    .lsu_trace_i (lsu_trace),
    .rvfi_o      (rvfi)
  );

  rvfi_checker u_checker (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .id_trace_i   (id_trace),
    .ctrl_evt_i   (ctrl_evt),
    .lsu_trace_i  (lsu_trace),
    .rvfi_i       (rvfi),
    .field_errs_o (field_errs),
    .proto_errs_o (proto_errs),
    .records_o    (records)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (16 + 4 * $size(rows) + 20) @(posedge clk);
    $display("Timeout: the run did not finish in %0d cycles", 16 + 4 * $size(rows) + 20);
    $display("TESTS FAILED");
    $finish;
  end

  task automatic drive_lsu(input logic valid, input logic [31:0] addr);
    lsu_trace.valid <= valid;
    lsu_trace.addr  <= addr;
    lsu_trace.rdata <= $random(seed);
    lsu_trace.wdata <= $random(seed);
  endtask

  // One cycle each for open, first response, second response and retire
  task automatic apply_row(input int idx);
    row_t r;
    r = rows[idx];
    @(posedge clk);
    ctrl_evt.instr_new     <= 1'b1;
    ctrl_evt.instr_ret     <= 1'b0;
    if (r.pc_set) begin
      ctrl_evt.pc_set     <= 1'b1;
      ctrl_evt.pc_mux     <= PC_EXC;
      ctrl_evt.exc_pc_mux <= r.exc;
    end
    id_trace.instr_rdata   <= r.insn;
    id_trace.instr_rdata_c <= r.insn[15:0];
    id_trace.is_compressed <= r.is_c;
    id_trace.rs1_addr      <= 5'(idx + 1);
    id_trace.rs2_addr      <= 5'(idx + 17);
    id_trace.rs1_data      <= $random(seed);
    id_trace.rs2_data      <= $random(seed);
    id_trace.rd_addr       <= r.rd;
    id_trace.rd_we         <= r.rd_we;
    id_trace.rd_wdata      <= r.rd_wdata;
    id_trace.pc_id         <= 32'h8000_0000 + 32'(idx * 8);
    id_trace.pc_if         <= 32'h8000_0000 + 32'(idx * 8) + (r.is_c ? 32'd2 : 32'd4);
    id_trace.priv          <= r.priv;
    id_trace.illegal       <= r.illegal;
    lsu_trace.we           <= r.store;
    lsu_trace.data_type    <= r.dtype;
    @(posedge clk);
    ctrl_evt.instr_new     <= 1'b0;
    ctrl_evt.pc_set        <= 1'b0;
    ctrl_evt.pc_mux        <= PC_BOOT;
    // Operands move on after decode
    id_trace.rs1_data      <= $random(seed);
    id_trace.rs2_data      <= $random(seed);
    drive_lsu(r.mem, r.addr);
    @(posedge clk);
    drive_lsu(r.mem, r.addr + 32'h40);
    @(posedge clk);
    lsu_trace.valid        <= 1'b0;
    ctrl_evt.instr_ret     <= 1'b1;
  endtask

  initial begin
    seed          = 51;
    id_trace      = '0;
    id_trace.priv = PRIV_LVL_M;
    ctrl_evt      = '0;
    lsu_trace     = '0;
    // insn, is_c, rd, rd_we, rd_wdata, mem, store, dtype, addr, pc_set, exc, illegal, priv
    rows[0] = {32'h00a5_0513, 1'b0, 5'd10, 1'b1, 32'h1111_2222, 1'b0, 1'b0, MEM_WORD,
               32'h0000_0000, 1'b0, EXC_PC_EXC, 1'b0, PRIV_LVL_M};
    rows[1] = {32'h0002_a583, 1'b0, 5'd11, 1'b1, 32'h3333_4444, 1'b1, 1'b0, MEM_WORD,
               32'h0000_1000, 1'b0, EXC_PC_EXC, 1'b0, PRIV_LVL_M};
    rows[2] = {32'h00b2_9223, 1'b0, 5'd5, 1'b0, 32'h5555_6666, 1'b1, 1'b1, MEM_HALF,
               32'h0000_2002, 1'b0, EXC_PC_EXC, 1'b0, PRIV_LVL_M};
    rows[3] = {32'h1234_8d05, 1'b1, 5'd0, 1'b1, 32'h7777_8888, 1'b1, 1'b1, MEM_BYTE,
               32'h0000_3003, 1'b0, EXC_PC_EXC, 1'b0, PRIV_LVL_U};
    rows[4] = {32'hffff_ffff, 1'b0, 5'd12, 1'b1, 32'h9999_aaaa, 1'b0, 1'b0, MEM_WORD,
               32'h0000_0000, 1'b0, EXC_PC_EXC, 1'b1, PRIV_LVL_U};
    rows[5] = {32'h3420_2573, 1'b0, 5'd10, 1'b1, 32'h0000_0002, 1'b1, 1'b0, MEM_BYTE,
               32'h0000_4001, 1'b1, EXC_PC_EXC, 1'b0, PRIV_LVL_M};
    rows[6] = {32'hcdef_4501, 1'b1, 5'd10, 1'b1, 32'hbbbb_cccc, 1'b1, 1'b0, MEM_HALF,
               32'h0000_5006, 1'b1, EXC_PC_DBD, 1'b0, PRIV_LVL_M};
    rows[7] = {32'h00c5_2023, 1'b0, 5'd0, 1'b0, 32'hdddd_eeee, 1'b1, 1'b1, MEM_WORD,
               32'h0000_6000, 1'b1, EXC_PC_IRQ, 1'b0, PRIV_LVL_M};
    repeat (16) @(posedge clk);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk);
    for (int i = 0; i < $size(rows); i++) begin
      apply_row(i);
    end
    @(posedge clk);
    ctrl_evt.instr_ret <= 1'b0;
    wait (records == $size(rows));
    repeat (3) @(posedge clk);
    $display("Run complete: %0d records, %0d field errors, %0d protocol errors",
             records, field_errs, proto_errs);
    if ((field_errs == 0) && (proto_errs == 0)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* rtl/rvfi_insn_track.sv */
////////////////////////////////////////////////////////////////////////////
// Instruction tracker
// Open-instruction flag and trap-entry state, source of the intr flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rvfi_insn_track (
  input  logic                clk,
  input  logic                rst_ni,
  input  rvfi_pkg::ctrl_evt_t ctrl_evt_i,
  output logic                insn_open_o,
  output logic                intr_o
);

  import rvfi_pkg::*;

  logic open_d;
  logic open_q;
  logic trap_entry;
  logic trap_d;
  logic trap_q;

  ////////////////////////////////////////////////////////////////////////////
  // Open instruction
  ////////////////////////////////////////////////////////////////////////////

  // Open from the instr_new cycle up to and including the retiring cycle
  assign open_d = ctrl_evt_i.instr_new | open_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q <= 1'b0;
    end else if (ctrl_evt_i.instr_ret) begin
      open_q <= 1'b0;
    end else begin
      open_q <= open_d;
    end
  end

  assign insn_open_o = open_d;

  ////////////////////////////////////////////////////////////////////////////
  // Trap entry
  ////////////////////////////////////////////////////////////////////////////

  // PC redirected to an exception or interrupt vector
  assign trap_entry = ctrl_evt_i.pc_set && (ctrl_evt_i.pc_mux == PC_EXC) &&
                      ((ctrl_evt_i.exc_pc_mux == EXC_PC_EXC) ||
                       (ctrl_evt_i.exc_pc_mux == EXC_PC_IRQ));

  always_comb begin
    trap_d = trap_q;
    if (trap_entry) begin
      trap_d = 1'b1;
    end else if (trap_q && ctrl_evt_i.instr_ret) begin
      // First handler instruction has retired
      trap_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_q <= 1'b0;
    end else begin
      trap_q <= trap_d;
    end
  end

  assign intr_o = trap_q & open_d;

  // A retirement needs an instruction opened now or on an earlier cycle
  a_ret_needs_open: assert property (@(posedge clk) disable iff (!rst_ni)
    ctrl_evt_i.instr_ret |-> (open_q || ctrl_evt_i.instr_new));

endmodule

/* rtl/rvfi_mem_capture.sv */
////////////////////////////////////////////////////////////////////////////
// Memory capture
// Byte mask decode and the first data-side response of the open insn
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rvfi_mem_capture (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  rvfi_pkg::lsu_trace_t        lsu_trace_i,
  input  logic                        instr_new_i,
  input  logic                        insn_open_i,
  output logic [rvfi_pkg::MASK_W-1:0] mem_mask_o,
  output logic [rvfi_pkg::XLEN-1:0]   mem_addr_o,
  output logic [rvfi_pkg::XLEN-1:0]   mem_rdata_o,
  output logic [rvfi_pkg::XLEN-1:0]   mem_wdata_o
);

  import rvfi_pkg::*;

  logic            taken_q;
  logic            taken_cur;
  logic            capture;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] rdata_q;
  logic [XLEN-1:0] wdata_q;

  // Byte enables by access size
  always_comb begin
    case (lsu_trace_i.data_type)
      MEM_WORD: mem_mask_o = 4'b1111;
      MEM_HALF: mem_mask_o = 4'b0011;
      MEM_BYTE: mem_mask_o = 4'b0001;
      default:  mem_mask_o = 4'b0000;
    endcase
  end

  // A new instruction rearms the capture
  assign taken_cur = taken_q & ~instr_new_i;
  assign capture   = lsu_trace_i.valid & insn_open_i & ~taken_cur;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q <= 1'b0;
      addr_q  <= '0;
      rdata_q <= '0;
      wdata_q <= '0;
    end else begin
      taken_q <= taken_cur | capture;
      addr_q  <= mem_addr_o;
      rdata_q <= mem_rdata_o;
      wdata_q <= mem_wdata_o;
    end
  end

  // Response visible in its own cycle and held afterwards
  assign mem_addr_o  = capture ? lsu_trace_i.addr  : addr_q;
  assign mem_rdata_o = capture ? lsu_trace_i.rdata : rdata_q;
  assign mem_wdata_o = capture ? lsu_trace_i.wdata : wdata_q;

  a_no_rsvd_type: assert property (@(posedge clk) disable iff (!rst_ni)
    lsu_trace_i.valid |-> (lsu_trace_i.data_type != MEM_RSVD));

endmodule

/* rtl/rvfi_output_reg.sv */
////////////////////////////////////////////////////////////////////////////
// Output register
// Registers the retirement record and keeps the retirement order count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rvfi_output_reg (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  rvfi_pkg::id_trace_t             id_trace_i,
  input  logic                            lsu_we_i,
  input  logic                            instr_ret_i,
  input  logic                            intr_i,
  input  logic [rvfi_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rvfi_pkg::XLEN-1:0]       rs2_data_i,
  input  logic [rvfi_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic [rvfi_pkg::XLEN-1:0]       rd_wdata_i,
  input  logic [rvfi_pkg::MASK_W-1:0]     mem_mask_i,
  input  logic [rvfi_pkg::XLEN-1:0]       mem_addr_i,
  input  logic [rvfi_pkg::XLEN-1:0]       mem_rdata_i,
  input  logic [rvfi_pkg::XLEN-1:0]       mem_wdata_i,
  output rvfi_pkg::rvfi_t                 rvfi_o
);

  import rvfi_pkg::*;

  logic [31:0] insn;
  rvfi_t       rvfi_q;

  // Compressed encodings are reported zero-extended
  always_comb begin
    if (id_trace_i.is_compressed) begin
      insn = {16'b0, id_trace_i.instr_rdata_c};
    end else begin
      insn = id_trace_i.instr_rdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Record register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_q      <= '0;
      rvfi_q.mode <= PRIV_LVL_M;
    end else begin
      rvfi_q.valid     <= instr_ret_i;
      // Count of records already presented
      rvfi_q.order     <= rvfi_q.order + ORDER_W'(rvfi_q.valid);
      rvfi_q.insn      <= insn;
      rvfi_q.trap      <= id_trace_i.illegal;
      rvfi_q.halt      <= 1'b0;
      rvfi_q.intr      <= intr_i;
      rvfi_q.mode      <= id_trace_i.priv;
      rvfi_q.rs1_addr  <= id_trace_i.rs1_addr;
      rvfi_q.rs2_addr  <= id_trace_i.rs2_addr;
      rvfi_q.rs1_rdata <= rs1_data_i;
      rvfi_q.rs2_rdata <= rs2_data_i;
      rvfi_q.rd_addr   <= rd_addr_i;
      rvfi_q.rd_wdata  <= rd_wdata_i;
      rvfi_q.pc_rdata  <= id_trace_i.pc_id;
      rvfi_q.pc_wdata  <= id_trace_i.pc_if;
      rvfi_q.mem_addr  <= mem_addr_i;
      rvfi_q.mem_rmask <= mem_mask_i;
      // Loads write nothing
      rvfi_q.mem_wmask <= lsu_we_i ? mem_mask_i : '0;
      rvfi_q.mem_rdata <= mem_rdata_i;
      rvfi_q.mem_wdata <= mem_wdata_i;
    end
  end

  assign rvfi_o = rvfi_q;

endmodule

/* rtl/rvfi_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// RVFI retirement tracer package
// Widths, encodings and the packed trace records used by every block
////////////////////////////////////////////////////////////////////////////

package rvfi_pkg;

  // Data path and record widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned ORDER_W    = 64;
  localparam int unsigned MASK_W     = XLEN / 8;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_H = 2'b10,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Next PC source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // Exception PC source
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // Access size with value 3 reserved
  typedef enum logic [1:0] {
    MEM_WORD = 2'd0,
    MEM_HALF = 2'd1,
    MEM_BYTE = 2'd2,
    MEM_RSVD = 2'd3
  } mem_type_e;

  ////////////////////////////////////////////////////////////////////////////
  // Trace records
  ////////////////////////////////////////////////////////////////////////////

  // Decode stage view of the instruction
  typedef struct packed {
    logic [31:0]           instr_rdata;
    logic [15:0]           instr_rdata_c;
    logic                  is_compressed;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       rd_wdata;
    logic                  rd_we;
    logic [XLEN-1:0]       pc_id;
    logic [XLEN-1:0]       pc_if;
    priv_lvl_e             priv;
    logic                  illegal;
  } id_trace_t;

  // Pipeline control events
  typedef struct packed {
    logic        instr_new;
    logic        instr_ret;
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
  } ctrl_evt_t;

  // Data side response
  typedef struct packed {
    logic            valid;
    logic            we;
    mem_type_e       data_type;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] wdata;
  } lsu_trace_t;

  // One retired instruction
  typedef struct packed {
    logic                  valid;
    logic [ORDER_W-1:0]    order;
    logic [31:0]           insn;
    logic                  trap;
    logic                  halt;
    logic                  intr;
    priv_lvl_e             mode;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       pc_rdata;
    logic [XLEN-1:0]       pc_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic [MASK_W-1:0]     mem_rmask;
    logic [MASK_W-1:0]     mem_wmask;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       mem_wdata;
  } rvfi_t;

endpackage

/* rtl/rvfi_reg_capture.sv */
////////////////////////////////////////////////////////////////////////////
// Register capture
// Holds source operands from instr_new and the rd write of the open insn
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rvfi_reg_capture (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  rvfi_pkg::id_trace_t             id_trace_i,
  input  logic                            instr_new_i,
  input  logic                            insn_open_i,
  output logic [rvfi_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rvfi_pkg::XLEN-1:0]       rs2_data_o,
  output logic [rvfi_pkg::REG_ADDR_W-1:0] rd_addr_o,
  output logic [rvfi_pkg::XLEN-1:0]       rd_wdata_o
);

  import rvfi_pkg::*;

  logic [XLEN-1:0]       rs1_data_d;
  logic [XLEN-1:0]       rs1_data_q;
  logic [XLEN-1:0]       rs2_data_d;
  logic [XLEN-1:0]       rs2_data_q;
  logic [REG_ADDR_W-1:0] rd_addr_d;
  logic [REG_ADDR_W-1:0] rd_addr_q;
  logic [XLEN-1:0]       rd_wdata_d;
  logic [XLEN-1:0]       rd_wdata_q;

  // Source data as read on the first decode cycle
  always_comb begin
    if (instr_new_i) begin
      rs1_data_d = id_trace_i.rs1_data;
      rs2_data_d = id_trace_i.rs2_data;
    end else begin
      rs1_data_d = rs1_data_q;
      rs2_data_d = rs2_data_q;
    end
  end

  // Destination write followed while the instruction is open
  always_comb begin
    if (insn_open_i) begin
      if (!id_trace_i.rd_we) begin
        rd_addr_d  = '0;
        rd_wdata_d = '0;
      end else begin
        rd_addr_d = id_trace_i.rd_addr;
        // x0 is hardwired, so its write data reads as zero
        if (id_trace_i.rd_addr == '0) begin
          rd_wdata_d = '0;
        end else begin
          rd_wdata_d = id_trace_i.rd_wdata;
        end
      end
    end else begin
      rd_addr_d  = rd_addr_q;
      rd_wdata_d = rd_wdata_q;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      rs1_data_q <= '0;
      rs2_data_q <= '0;
      rd_addr_q  <= '0;
      rd_wdata_q <= '0;
    end else begin
      rs1_data_q <= rs1_data_d;
      rs2_data_q <= rs2_data_d;
      rd_addr_q  <= rd_addr_d;
      rd_wdata_q <= rd_wdata_d;
    end
  end

  assign rs1_data_o = rs1_data_d;
  assign rs2_data_o = rs2_data_d;
  assign rd_addr_o  = rd_addr_d;
  assign rd_wdata_o = rd_wdata_d;

endmodule

/* rtl/rvfi_tracer.sv */
////////////////////////////////////////////////////////////////////////////
// RVFI retirement tracer
// Builds one formal-interface record per retired instruction
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rvfi_tracer (
  input  logic                 clk,
  input  logic                 rst_ni,
  input  rvfi_pkg::id_trace_t  id_trace_i,
  input  rvfi_pkg::ctrl_evt_t  ctrl_evt_i,
  input  rvfi_pkg::lsu_trace_t lsu_trace_i,
  output rvfi_pkg::rvfi_t      rvfi_o
);

  import rvfi_pkg::*;

  logic                  insn_open;
  logic                  intr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       rd_wdata;
  logic [MASK_W-1:0]     mem_mask;
  logic [XLEN-1:0]       mem_addr;
  logic [XLEN-1:0]       mem_rdata;
  logic [XLEN-1:0]       mem_wdata;

  rvfi_insn_track u_insn_track (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .ctrl_evt_i  (ctrl_evt_i),
    .insn_open_o (insn_open),
    .intr_o      (intr)
  );

  rvfi_reg_capture u_reg_capture (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .id_trace_i  (id_trace_i),
    .instr_new_i (ctrl_evt_i.instr_new),
    .insn_open_i (insn_open),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data),
    .rd_addr_o   (rd_addr),
    .rd_wdata_o  (rd_wdata)
  );

  rvfi_mem_capture u_mem_capture (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .lsu_trace_i (lsu_trace_i),
    .instr_new_i (ctrl_evt_i.instr_new),
    .insn_open_i (insn_open),
    .mem_mask_o  (mem_mask),
    .mem_addr_o  (mem_addr),
    .mem_rdata_o (mem_rdata),
    .mem_wdata_o (mem_wdata)
  );

  rvfi_output_reg u_output_reg (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .id_trace_i  (id_trace_i),
    .lsu_we_i    (lsu_trace_i.we),
    .instr_ret_i (ctrl_evt_i.instr_ret),
    .intr_i      (intr),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .rd_addr_i   (rd_addr),
    .rd_wdata_i  (rd_wdata),
    .mem_mask_i  (mem_mask),
    .mem_addr_i  (mem_addr),
    .mem_rdata_i (mem_rdata),
    .mem_wdata_i (mem_wdata),
    .rvfi_o      (rvfi_o)
  );

endmodule

/* verilog.f */
rtl/rvfi_pkg.sv
rtl/rvfi_insn_track.sv
rtl/rvfi_reg_capture.sv
rtl/rvfi_mem_capture.sv
rtl/rvfi_output_reg.sv
rtl/rvfi_tracer.sv
dv/rvfi_checker.sv
dv/tb_rvfi_tracer.sv
